// ==== logic/chan_buf_params.svh ====
// Channel buffer build constants: beat payload width, FIFO depth, counter and burst size widths
`ifndef CB_PARAMS_SVH
`define CB_PARAMS_SVH

// ====================
// Beat payload
// ====================

// Payload bits per beat beside the last flag
`define CB_DATA_W 32

// ====================
// Storage and counters
// ====================

// Entries in the beat FIFO
`define CB_DEPTH 16
// Counters cover 0 to CB_DEPTH+2 (FIFO plus the two skid slots)
`define CB_CNT_W 6
// Burst size carried by alloc and drain requests
`define CB_SIZE_W 8

`endif

// ==== logic/chan_buf_pkg.sv ====
// Channel buffer shared types: beat payload, counter and size types, skid occupancy states
`include "chan_buf_params.svh"

`default_nettype none

package chan_buf_pkg;

        // ====================
        // Data path types
        // ====================

        // One streamed beat
        // Last flag sits in the top bit
        typedef struct packed {
                logic                  last;
                logic [`CB_DATA_W-1:0] data;
        } beat_t;

        // ====================
        // Ledger and fill types
        // ====================

        // Space free, data available and FIFO fill level
        typedef logic [`CB_CNT_W-1:0] cnt_t;

        // Burst length in an alloc or drain request
        typedef logic [`CB_SIZE_W-1:0] size_t;

        // ====================
        // Bridge state
        // ====================

        // Number of beats held in the two-entry skid
        typedef enum logic [1:0] {
                BR_EMPTY,
                BR_ONE,
                BR_TWO
        } bridge_state_e;

endpackage

`default_nettype wire

// ==== logic/credit_ledger.sv ====
// Credit ledger: registered space-free and data-available pools with alloc and drain handshakes
`include "chan_buf_params.svh"

`default_nettype none

module credit_ledger (
        input  logic                  clk,
        input  logic                  arst_n,
        // Producer reserves room for a burst
        input  logic                  alloc_valid,
        input  chan_buf_pkg::size_t   alloc_size,
        output logic                  alloc_ready,
        // Consumer claims buffered beats
        input  logic                  drain_valid,
        input  chan_buf_pkg::size_t   drain_size,
        output logic                  drain_ready,
        // Stream handshake strobes from the top level
        input  logic                  in_fire,
        input  logic                  out_fire,
        // Pool levels
        output chan_buf_pkg::cnt_t    space_free,
        output chan_buf_pkg::cnt_t    data_avail
);
        import chan_buf_pkg::*;

        // Credit pool never exceeds the FIFO depth
        localparam cnt_t SPACE_MAX = cnt_t'(`CB_DEPTH);
        // Claimable beats bounded by FIFO plus skid storage
        localparam cnt_t AVAIL_MAX = cnt_t'(`CB_DEPTH + 2);

        logic alloc_fire;
        logic drain_fire;
        cnt_t space_after_alloc;
        cnt_t avail_after_drain;
        cnt_t space_next;
        cnt_t avail_next;

        // ====================
        // Request acceptance
        // ====================

        // A request is granted only if its pool covers the whole burst
        assign alloc_ready = alloc_size <= size_t'(space_free);
        assign drain_ready = drain_size <= size_t'(data_avail);

        assign alloc_fire = alloc_valid && alloc_ready;
        assign drain_fire = drain_valid && drain_ready;

        // ====================
        // Pool updates
        // ====================

        always_comb begin
                // Granted bursts come off the pool first
                space_after_alloc = space_free;
                if (alloc_fire) begin
                        space_after_alloc = space_free - cnt_t'(alloc_size);
                end
                avail_after_drain = data_avail;
                if (drain_fire) begin
                        avail_after_drain = data_avail - cnt_t'(drain_size);
                end

                // Output transfer returns one credit
                space_next = space_after_alloc;
                if (out_fire && (space_after_alloc < SPACE_MAX)) begin
                        space_next = space_after_alloc + cnt_t'(1);
                end

                // Input transfer makes one more beat claimable
                avail_next = avail_after_drain;
                if (in_fire && (avail_after_drain < AVAIL_MAX)) begin
                        avail_next = avail_after_drain + cnt_t'(1);
                end
        end

        // Same-cycle events land together on the next edge
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        space_free <= SPACE_MAX;
                        data_avail <= '0;
                end else begin
                        space_free <= space_next;
                        data_avail <= avail_next;
                end
        end

endmodule

`default_nettype wire

// ==== logic/beat_fifo.sv ====
// Beat FIFO: circular store with fill count and a registered one-cycle read port
`include "chan_buf_params.svh"

`default_nettype none

module beat_fifo #(
        parameter int DEPTH = `CB_DEPTH
) (
        input  logic                  clk,
        input  logic                  arst_n,
        // Write side, valid/ready
        input  logic                  in_valid,
        input  chan_buf_pkg::beat_t   in_beat,
        output logic                  in_ready,
        // Read request, data returns one edge later
        input  logic                  rd_en,
        output chan_buf_pkg::beat_t   rd_beat,
        // Fill level
        output chan_buf_pkg::cnt_t    count
);
        import chan_buf_pkg::*;

        localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

        typedef logic [AW-1:0] ptr_t;

        beat_t mem [DEPTH];
        ptr_t  wr_ptr;
        ptr_t  rd_ptr;
        logic  wr_fire;
        logic  rd_fire;

        // Advance a pointer with wrap at the last entry
        function automatic ptr_t ptr_inc(input ptr_t ptr);
                ptr_t nxt;
                nxt = ptr + ptr_t'(1);
                if (ptr == ptr_t'(DEPTH - 1)) begin
                        nxt = '0;
                end
                return nxt;
        endfunction

        // ====================
        // Handshakes
        // ====================

        // Writes accepted while not full
        assign in_ready = count < cnt_t'(DEPTH);
        assign wr_fire  = in_valid && in_ready;
        // Pop only while an entry is held
        assign rd_fire  = rd_en && (count != '0);

        // ====================
        // Pointers and count
        // ====================

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (wr_fire) begin
                                wr_ptr <= ptr_inc(wr_ptr);
                        end
                        if (rd_fire) begin
                                rd_ptr <= ptr_inc(rd_ptr);
                        end
                        // Simultaneous push and pop leave the level unchanged
                        case ({wr_fire, rd_fire})
                                2'b10:   count <= count + cnt_t'(1);
                                2'b01:   count <= count - cnt_t'(1);
                                default: count <= count;
                        endcase
                end
        end

        // ====================
        // Storage
        // ====================

        always_ff @(posedge clk) begin
                if (wr_fire) begin
                        mem[wr_ptr] <= in_beat;
                end
        end

        // Head pops into the output register for an SRAM-like read
        always_ff @(posedge clk) begin
                if (rd_fire) begin
                        rd_beat <= mem[rd_ptr];
                end
        end

endmodule

`default_nettype wire

// ==== logic/latency_bridge.sv ====
// Latency bridge: two-entry skid that hides the FIFO read latency behind valid/ready
`default_nettype none

module latency_bridge (
        input  logic                  clk,
        input  logic                  arst_n,
        // FIFO side
        input  chan_buf_pkg::cnt_t    fifo_count,
        output logic                  rd_en,
        input  chan_buf_pkg::beat_t   rd_beat,
        // Output stream
        output logic                  out_valid,
        output chan_buf_pkg::beat_t   out_beat,
        input  logic                  out_ready
);
        import chan_buf_pkg::*;

        bridge_state_e state;
        bridge_state_e state_next;
        logic          rd_pending;
        logic          out_fire;
        logic [1:0]    held;
        logic [2:0]    load;
        beat_t         slot0;
        beat_t         slot1;

        // Oldest held beat always sits in slot0
        assign out_valid = state != BR_EMPTY;
        assign out_beat  = slot0;
        assign out_fire  = out_valid && out_ready;

        // ====================
        // Read issue
        // ====================

        always_comb begin
                case (state)
                        BR_ONE:  held = 2'd1;
                        BR_TWO:  held = 2'd2;
                        default: held = 2'd0;
                endcase
        end

        // Beats held after this edge including the one in flight
        assign load  = 3'(held) + 3'(rd_pending) - 3'(out_fire);
        // Read only if a skid slot is free for the returning beat
        assign rd_en = (fifo_count != '0) && (load < 3'd2);

        // ====================
        // Skid occupancy
        // ====================

        always_comb begin
                state_next = state;
                case ({rd_pending, out_fire})
                        2'b10: state_next = (state == BR_EMPTY) ? BR_ONE : BR_TWO;
                        2'b01: state_next = (state == BR_TWO) ? BR_ONE : BR_EMPTY;
                        default: state_next = state;
                endcase
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        state      <= BR_EMPTY;
                        rd_pending <= 1'b0;
                end else begin
                        state      <= state_next;
                        rd_pending <= rd_en;
                end
        end

        // Shift on pop and land the returning beat in the next free slot
        always_ff @(posedge clk) begin
                if (out_fire && (state == BR_TWO)) begin
                        slot0 <= slot1;
                end
                if (rd_pending) begin
                        if ((state == BR_EMPTY) || ((state == BR_ONE) && out_fire)) begin
                                slot0 <= rd_beat;
                        end else begin
                                slot1 <= rd_beat;
                        end
                end
        end

endmodule

`default_nettype wire

// ==== logic/chan_buf_unit.sv ====
// Channel buffer top: credit ledger, beat FIFO and latency bridge on one stream
`include "chan_buf_params.svh"

`default_nettype none

module chan_buf_unit (
        input  logic                  clk,
        input  logic                  arst_n,
        // Producer stream
        input  logic                  in_valid,
        input  chan_buf_pkg::beat_t   in_beat,
        output logic                  in_ready,
        // Consumer stream
        output logic                  out_valid,
        output chan_buf_pkg::beat_t   out_beat,
        input  logic                  out_ready,
        // Producer space reservation
        input  logic                  alloc_valid,
        input  chan_buf_pkg::size_t   alloc_size,
        output logic                  alloc_ready,
        // Consumer beat claim
        input  logic                  drain_valid,
        input  chan_buf_pkg::size_t   drain_size,
        output logic                  drain_ready,
        // Ledger levels
        output chan_buf_pkg::cnt_t    space_free,
        output chan_buf_pkg::cnt_t    data_avail
);
        import chan_buf_pkg::*;

        logic  in_fire;
        logic  out_fire;
        logic  rd_en;
        beat_t rd_beat;
        cnt_t  fifo_count;

        // Stream transfers that move the ledger
        assign in_fire  = in_valid && in_ready;
        assign out_fire = out_valid && out_ready;

        // Ledger is advisory and never gates the FIFO write
        credit_ledger u_ledger (
                .clk         (clk),
                .arst_n      (arst_n),
                .alloc_valid (alloc_valid),
                .alloc_size  (alloc_size),
                .alloc_ready (alloc_ready),
                .drain_valid (drain_valid),
                .drain_size  (drain_size),
                .drain_ready (drain_ready),
                .in_fire     (in_fire),
                .out_fire    (out_fire),
                .space_free  (space_free),
                .data_avail  (data_avail)
        );

        beat_fifo #(
                .DEPTH (`CB_DEPTH)
        ) u_fifo (
                .clk      (clk),
                .arst_n   (arst_n),
                .in_valid (in_valid),
                .in_beat  (in_beat),
                .in_ready (in_ready),
                .rd_en    (rd_en),
                .rd_beat  (rd_beat),
                .count    (fifo_count)
        );

        latency_bridge u_bridge (
                .clk        (clk),
                .arst_n     (arst_n),
                .fifo_count (fifo_count),
                .rd_en      (rd_en),
                .rd_beat    (rd_beat),
                .out_valid  (out_valid),
                .out_beat   (out_beat),
                .out_ready  (out_ready)
        );

endmodule

`default_nettype wire

// ==== tests/chan_buf_assert.sv ====
// Channel buffer assertions: output handshake hold, credit bound and skid occupancy
`include "chan_buf_params.svh"

`default_nettype none

module chan_buf_assert (
        input  logic                        clk,
        input  logic                        arst_n,
        input  logic                        out_valid,
        input  logic                        out_ready,
        input  chan_buf_pkg::beat_t         out_beat,
        input  chan_buf_pkg::cnt_t          space_free,
        input  chan_buf_pkg::bridge_state_e state,
        input  logic                        rd_pending
);
        import chan_buf_pkg::*;

        // Stalled output keeps valid and contents
        assert property (@(posedge clk) disable iff (!arst_n)
                (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else $error("out_valid dropped or out_beat changed while stalled");

        // Credit pool bounded by FIFO depth
        assert property (@(posedge clk) disable iff (!arst_n)
                space_free <= cnt_t'(`CB_DEPTH))
        else $error("space_free above FIFO depth");

        // No read may land in a full skid
        assert property (@(posedge clk) disable iff (!arst_n)
                !((state == BR_TWO) && rd_pending))
        else $error("read pending into full skid");

endmodule

bind chan_buf_unit chan_buf_assert u_assert (
        .clk        (clk),
        .arst_n     (arst_n),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat),
        .space_free (space_free),
        .state      (u_bridge.state),
        .rd_pending (u_bridge.rd_pending)
);

`default_nettype wire

// ==== tests/chan_buf_tb.sv ====
// Channel buffer testbench: directed tests on ordering, credits, claims, capacity and latency
`default_nettype none

module chan_buf_tb;
        import chan_buf_pkg::*;

        // Cycle budget for the whole test sequence
        localparam int MAX_CYCLES = 4000;

        logic  clk;
        logic  arst_n;
        logic  in_valid;
        beat_t in_beat;
        logic  in_ready;
        logic  out_valid;
        beat_t out_beat;
        logic  out_ready;
        logic  alloc_valid;
        size_t alloc_size;
        logic  alloc_ready;
        logic  drain_valid;
        size_t drain_size;
        logic  drain_ready;
        cnt_t  space_free;
        cnt_t  data_avail;

        logic [31:0] rng_state;
        int          cycle_count = 0;
        beat_t       expected[$];

        chan_buf_unit UUT (
                .clk         (clk),
                .arst_n      (arst_n),
                .in_valid    (in_valid),
                .in_beat     (in_beat),
                .in_ready    (in_ready),
                .out_valid   (out_valid),
                .out_beat    (out_beat),
                .out_ready   (out_ready),
                .alloc_valid (alloc_valid),
                .alloc_size  (alloc_size),
                .alloc_ready (alloc_ready),
                .drain_valid (drain_valid),
                .drain_size  (drain_size),
                .drain_ready (drain_ready),
                .space_free  (space_free),
                .data_avail  (data_avail)
        );

        // ====================
        // Clock and watchdog
        // ====================

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= MAX_CYCLES) begin
                        stop_with_error("Timeout: tests did not finish in the cycle limit");
                end
        end

        // ====================
        // Helpers
        // ====================

        task automatic stop_with_error(input string msg);
                $display("%s", msg);
                $display("Regression failed");
                $fatal(1);
        endtask

        task automatic check_value(input string name, input logic [63:0] actual,
                                   input logic [63:0] exp);
                if (actual !== exp) begin
                        $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, actual, exp);
                        stop_with_error("Value mismatch");
                end
        endtask

        function automatic logic [31:0] xorshift();
                rng_state = rng_state ^ (rng_state << 13);
                rng_state = rng_state ^ (rng_state >> 17);
                rng_state = rng_state ^ (rng_state << 5);
                return rng_state;
        endfunction

        function automatic beat_t random_beat();
                beat_t       b;
                logic [31:0] r;
                b.data = xorshift();
                r      = xorshift();
                b.last = r[0];
                return b;
        endfunction

        // Called at #1 after a falling edge when a transfer is due
        task automatic take_output();
                beat_t exp;
                if (expected.size() == 0) begin
                        stop_with_error("Output beat appeared with no beat outstanding");
                end
                exp = expected.pop_front();
                check_value("out_beat", 64'(out_beat), 64'(exp));
        endtask

        task automatic write_beats(input int n);
                beat_t nb;
                for (int i = 0; i < n; i++) begin
                        nb = random_beat();
                        @(negedge clk);
                        in_valid = 1'b1;
                        in_beat  = nb;
                        #1;
                        while (!in_ready) begin
                                @(negedge clk);
                                #1;
                        end
                        expected.push_back(nb);
                end
                @(negedge clk);
                in_valid = 1'b0;
        endtask

        task automatic read_beats(input int n);
                int got;
                got = 0;
                while (got < n) begin
                        @(negedge clk);
                        out_ready = 1'b1;
                        #1;
                        if (out_valid) begin
                                take_output();
                                got++;
                        end
                end
                @(negedge clk);
                out_ready = 1'b0;
        endtask

        // ====================
        // Directed tests
        // ====================

        task automatic reset_defaults();
                check_value("space_free", 64'(space_free), 64'(16));
                check_value("data_avail", 64'(data_avail), 64'(0));
                check_value("out_valid", 64'(out_valid), 64'(0));
                check_value("in_ready", 64'(in_ready), 64'(1));
        endtask

        task automatic drain_claims();
                write_beats(5);
                check_value("data_avail", 64'(data_avail), 64'(5));
                drain_valid = 1'b1;
                drain_size  = 8'd6;
                #1;
                check_value("drain_ready", 64'(drain_ready), 64'(0));
                @(negedge clk);
                drain_valid = 1'b0;
                @(negedge clk);
                drain_valid = 1'b1;
                drain_size  = 8'd5;
                #1;
                check_value("drain_ready", 64'(drain_ready), 64'(1));
                @(negedge clk);
                drain_valid = 1'b0;
                #1;
                check_value("data_avail", 64'(data_avail), 64'(0));
                read_beats(5);
        endtask

        task automatic alloc_credits();
                @(negedge clk);
                alloc_valid = 1'b1;
                alloc_size  = 8'd10;
                #1;
                check_value("alloc_ready", 64'(alloc_ready), 64'(1));
                @(negedge clk);
                alloc_valid = 1'b0;
                #1;
                check_value("space_free", 64'(space_free), 64'(6));
                @(negedge clk);
                alloc_valid = 1'b1;
                alloc_size  = 8'd8;
                #1;
                check_value("alloc_ready", 64'(alloc_ready), 64'(0));
                @(negedge clk);
                alloc_valid = 1'b0;
                write_beats(2);
                read_beats(2);
                check_value("space_free", 64'(space_free), 64'(8));
                alloc_valid = 1'b1;
                #1;
                check_value("alloc_ready", 64'(alloc_ready), 64'(1));
                @(negedge clk);
                alloc_valid = 1'b0;
                #1;
                check_value("space_free", 64'(space_free), 64'(0));
        endtask

        task automatic ordered_stream();
                int          sent;
                int          got;
                logic [31:0] r;
                beat_t       nb;
                sent = 0;
                got  = 0;
                nb   = random_beat();
                while (got < 60) begin
                        @(negedge clk);
                        in_valid  = (sent < 60);
                        in_beat   = nb;
                        r         = xorshift();
                        out_ready = r[3];
                        #1;
                        if (in_valid && in_ready) begin
                                expected.push_back(nb);
                                sent++;
                                nb = random_beat();
                        end
                        if (out_valid && out_ready) begin
                                take_output();
                                got++;
                        end
                end
                @(negedge clk);
                in_valid  = 1'b0;
                out_ready = 1'b0;
                #1;
                // Nothing may follow the last expected beat
                check_value("out_valid", 64'(out_valid), 64'(0));
        endtask

        task automatic backpressure_capacity();
                int    accepted;
                beat_t nb;
                accepted = 0;
                nb       = random_beat();
                // Offer a beat on every cycle the FIFO has room
                for (int i = 0; i < 40; i++) begin
                        @(negedge clk);
                        in_valid = in_ready;
                        in_beat  = nb;
                        if (in_ready) begin
                                expected.push_back(nb);
                                accepted++;
                                nb = random_beat();
                        end
                end
                @(negedge clk);
                in_valid = 1'b0;
                check_value("accepted", 64'(accepted), 64'(18));
                read_beats(18);
                #1;
                check_value("out_valid", 64'(out_valid), 64'(0));
        endtask

        task automatic write_to_output_latency();
                int    lat;
                beat_t nb;
                nb = random_beat();
                @(negedge clk);
                out_ready = 1'b1;
                in_valid  = 1'b1;
                in_beat   = nb;
                #1;
                check_value("in_ready", 64'(in_ready), 64'(1));
                expected.push_back(nb);
                // Input transfer edge has passed, no cycle counted yet
                @(negedge clk);
                in_valid = 1'b0;
                lat      = 0;
                #1;
                while (!out_valid) begin
                        @(negedge clk);
                        lat++;
                        #1;
                end
                check_value("latency", 64'(lat), 64'(2));
                take_output();
                @(negedge clk);
                out_ready = 1'b0;
        endtask

        // ====================
        // Sequence
        // ====================

        initial begin
                rng_state   = 32'd64;
                arst_n      = 1'b0;
                in_valid    = 1'b0;
                in_beat     = '0;
                out_ready   = 1'b0;
                alloc_valid = 1'b0;
                alloc_size  = '0;
                drain_valid = 1'b0;
                drain_size  = '0;
                repeat (8) @(posedge clk);
                @(negedge clk);
                arst_n = 1'b1;
                #1;
                reset_defaults();
                drain_claims();
                alloc_credits();
                ordered_stream();
                backpressure_capacity();
                write_to_output_latency();
                if (expected.size() == 0) begin
                        $display("Regression passed");
                        $finish;
                end else begin
                        $display("Beats left in the scoreboard at the end");
                        $display("Regression failed");
                        $fatal(1);
                end
        end

endmodule

`default_nettype wire

// ==== chan_buf_unit.f ====
+incdir+logic
logic/chan_buf_pkg.sv
logic/credit_ledger.sv
logic/beat_fifo.sv
logic/latency_bridge.sv
logic/chan_buf_unit.sv
tests/chan_buf_assert.sv
tests/chan_buf_tb.sv

// ==== Makefile ====
# Verilator build and run for the channel buffer testbench

VERILATOR ?= verilator
TOP       ?= chan_buf_tb
FILELIST  ?= chan_buf_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard logic/*.sv) $(wildcard logic/*.svh) $(wildcard tests/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
